// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS = --binary --timing --assert -Wno-fatal
TOP = tb_pci_master
FILELIST = filelist.f
LOG = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and check the log for the pass message"
	@echo "  clean  remove build output and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "TB PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// ==== filelist.f ====
+incdir+rtl
rtl/pci_bridge_pkg.sv
rtl/pci_write_engine.sv
rtl/pci_read_engine.sv
rtl/pci_bus_arbiter.sv
rtl/pci_master_top.sv
tb/pci_core_model.sv
tb/pci_master_chk.sv
tb/tb_pci_master.sv

// ==== rtl/pci_bridge_defines.svh ====
`ifndef PCI_BRIDGE_DEFINES_SVH
`define PCI_BRIDGE_DEFINES_SVH

// Datapath widths, tied to the 32-bit PCI core
`define PCI_DWORD_W 32
`define PCI_BE_W 4
`define PCI_CMD_W 4

// User channel widths
`define PCI_ID_W 4
`define PCI_LEN_W 8
`define PCI_IDX_W 10
`define PCI_CLS_W 8

// Write data buffer, the index wraps at this depth
`define PCI_BUF_DEPTH 1024

// Bus command codes driven on m_cbe during the address phase
`define PCI_CMD_MEM_READ 4'h6
`define PCI_CMD_MEM_WRITE 4'h7
`define PCI_CMD_MEM_READ_MUL 4'hC
`define PCI_CMD_MEM_READ_LN 4'hE

// Word returned for every beat of a read that was master-aborted
`define PCI_FILL_WORD 32'hFFFF_FFFF

`endif

// ==== rtl/pci_bridge_pkg.sv ====
`default_nettype none
`include "pci_bridge_defines.svh"

package pci_bridge_pkg;

	typedef logic [`PCI_DWORD_W-1:0] dword_t;
	typedef logic [`PCI_BE_W-1:0] byte_en_t; // Active low on the bus
	typedef logic [`PCI_CMD_W-1:0] bus_cmd_t;
	typedef logic [`PCI_ID_W-1:0] txn_id_t;
	typedef logic [`PCI_LEN_W-1:0] beat_len_t; // Beat count minus one
	typedef logic [`PCI_IDX_W-1:0] buf_idx_t;

	typedef enum logic [2:0] {
		WR_IDLE,
		WR_REQ, // Waiting for the arbiter
		WR_ADDR, // Request issued, waiting for the address phase
		WR_DATA,
		WR_CONT, // Disconnected, giving the bus back before retrying
		WR_RESP
	} wr_state_t;

	typedef enum logic [2:0] {
		RD_IDLE,
		RD_REQ,
		RD_ADDR,
		RD_DATA,
		RD_CONT,
		RD_FILL, // Padding the beats lost to an abort
		RD_RESP
	} rd_state_t;

	typedef enum logic [1:0] {
		ARB_IDLE,
		ARB_WR,
		ARB_RD
	} arb_state_t;

endpackage

`default_nettype wire

// ==== rtl/pci_bus_arbiter.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "pci_bridge_defines.svh"

module pci_bus_arbiter (
	input wire clk,
	input wire rst,
	input wire wr_req,
	input wire rd_req,
	output logic wr_gnt,
	output logic rd_gnt,
	input wire pci_bridge_pkg::dword_t wr_addr,
	input wire pci_bridge_pkg::dword_t wr_data,
	input wire pci_bridge_pkg::byte_en_t wr_cbe,
	input wire wr_complete,
	input wire pci_bridge_pkg::dword_t rd_addr,
	input wire pci_bridge_pkg::bus_cmd_t rd_cmd,
	input wire m_addr_n,
	input wire rdata_ready,
	output pci_bridge_pkg::dword_t adio_in,
	output pci_bridge_pkg::bus_cmd_t m_cbe,
	output logic request,
	output logic request_hold,
	output logic m_wrdn,
	output logic complete,
	output logic m_ready
);

	pci_bridge_pkg::arb_state_t state;
	logic last_wr; // Write engine won the last grant
	logic owner_wr; // Owner of the data phase, taken at each address phase
	logic data_wr;

	assign wr_gnt = state == pci_bridge_pkg::ARB_WR;
	assign rd_gnt = state == pci_bridge_pkg::ARB_RD;

	// A read can still be finishing its last beat after its grant is gone
	assign data_wr = !m_addr_n ? wr_gnt : owner_wr;

	assign adio_in = m_addr_n ? wr_data : (wr_gnt ? wr_addr : rd_addr);
	assign m_cbe = !m_addr_n ? (wr_gnt ? `PCI_CMD_MEM_WRITE : rd_cmd) :
		(data_wr ? wr_cbe : '0);
	assign m_wrdn = wr_gnt;
	assign complete = data_wr ? wr_complete : !rd_req;
	assign m_ready = data_wr || rdata_ready;
	assign request_hold = 1'b0; // Every tenure starts from a fresh request

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state <= pci_bridge_pkg::ARB_IDLE;
			request <= 1'b0;
			last_wr <= 1'b0;
			owner_wr <= 1'b1;
		end else begin
			request <= 1'b0;
			if (!m_addr_n)
				owner_wr <= wr_gnt;
			case (state)
				pci_bridge_pkg::ARB_IDLE: begin
					if (wr_req && (!rd_req || !last_wr)) begin
						request <= 1'b1;
						last_wr <= 1'b1;
						state <= pci_bridge_pkg::ARB_WR;
					end else if (rd_req) begin
						request <= 1'b1;
						last_wr <= 1'b0;
						state <= pci_bridge_pkg::ARB_RD;
					end
				end
				pci_bridge_pkg::ARB_WR: begin
					if (!wr_req)
						state <= pci_bridge_pkg::ARB_IDLE;
				end
				pci_bridge_pkg::ARB_RD: begin
					if (!rd_req)
						state <= pci_bridge_pkg::ARB_IDLE;
				end
				default: state <= pci_bridge_pkg::ARB_IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== rtl/pci_master_top.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "pci_bridge_defines.svh"

module pci_master_top (
	input wire clk,
	input wire rst,
	output pci_bridge_pkg::dword_t adio_in,
	input wire pci_bridge_pkg::dword_t adio_out,
	output logic request,
	output logic request_hold,
	output pci_bridge_pkg::bus_cmd_t m_cbe,
	output logic m_wrdn,
	output logic complete,
	output logic m_ready,
	input wire m_data_vld,
	input wire m_src_en,
	input wire time_out,
	input wire m_data,
	input wire m_addr_n,
	input wire stopq_n,
	input wire pci_bridge_pkg::txn_id_t wcmd_id,
	input wire pci_bridge_pkg::beat_len_t wcmd_len,
	input wire pci_bridge_pkg::dword_t wcmd_addr,
	input wire wcmd_valid,
	output logic wcmd_ready,
	output pci_bridge_pkg::buf_idx_t wdata_idx,
	input wire pci_bridge_pkg::dword_t wdata_dout,
	input wire pci_bridge_pkg::byte_en_t wdata_strb,
	output pci_bridge_pkg::txn_id_t wresp_id,
	output pci_bridge_pkg::beat_len_t wresp_len,
	output logic wresp_err,
	output logic wresp_valid,
	input wire wresp_ready,
	input wire pci_bridge_pkg::txn_id_t rcmd_id,
	input wire pci_bridge_pkg::beat_len_t rcmd_len,
	input wire pci_bridge_pkg::dword_t rcmd_addr,
	input wire rcmd_valid,
	output logic rcmd_ready,
	output pci_bridge_pkg::txn_id_t rresp_id,
	output pci_bridge_pkg::beat_len_t rresp_len,
	output logic rresp_err,
	output logic rresp_valid,
	input wire rresp_ready,
	output pci_bridge_pkg::dword_t rdata_din,
	output logic rdata_valid,
	input wire rdata_ready,
	input wire [`PCI_CLS_W-1:0] cacheline_size
);

	logic wr_req;
	logic rd_req;
	logic wr_gnt;
	logic rd_gnt;
	logic wr_complete;
	pci_bridge_pkg::dword_t wr_addr;
	pci_bridge_pkg::dword_t wr_data;
	pci_bridge_pkg::byte_en_t wr_cbe;
	pci_bridge_pkg::dword_t rd_addr;
	pci_bridge_pkg::bus_cmd_t rd_cmd;

	pci_write_engine u_write_engine (
		.clk(clk),
		.rst(rst),
		.wcmd_id(wcmd_id),
		.wcmd_len(wcmd_len),
		.wcmd_addr(wcmd_addr),
		.wcmd_valid(wcmd_valid),
		.wcmd_ready(wcmd_ready),
		.wdata_idx(wdata_idx),
		.wdata_dout(wdata_dout),
		.wdata_strb(wdata_strb),
		.wresp_id(wresp_id),
		.wresp_len(wresp_len),
		.wresp_err(wresp_err),
		.wresp_valid(wresp_valid),
		.wresp_ready(wresp_ready),
		.bus_req(wr_req),
		.bus_gnt(wr_gnt),
		.wr_addr(wr_addr),
		.wr_data(wr_data),
		.wr_cbe(wr_cbe),
		.wr_complete(wr_complete),
		.m_data_vld(m_data_vld),
		.m_src_en(m_src_en),
		.m_data(m_data),
		.m_addr_n(m_addr_n),
		.stopq_n(stopq_n),
		.time_out(time_out)
	);

	pci_read_engine u_read_engine (
		.clk(clk),
		.rst(rst),
		.rcmd_id(rcmd_id),
		.rcmd_len(rcmd_len),
		.rcmd_addr(rcmd_addr),
		.rcmd_valid(rcmd_valid),
		.rcmd_ready(rcmd_ready),
		.rresp_id(rresp_id),
		.rresp_len(rresp_len),
		.rresp_err(rresp_err),
		.rresp_valid(rresp_valid),
		.rresp_ready(rresp_ready),
		.rdata_din(rdata_din),
		.rdata_valid(rdata_valid),
		.rdata_ready(rdata_ready),
		.adio_out(adio_out),
		.cacheline_size(cacheline_size),
		.bus_req(rd_req),
		.bus_gnt(rd_gnt),
		.rd_addr(rd_addr),
		.rd_cmd(rd_cmd),
		.m_data_vld(m_data_vld),
		.m_data(m_data),
		.m_addr_n(m_addr_n),
		.stopq_n(stopq_n),
		.time_out(time_out)
	);

	pci_bus_arbiter u_bus_arbiter (
		.clk(clk),
		.rst(rst),
		.wr_req(wr_req),
		.rd_req(rd_req),
		.wr_gnt(wr_gnt),
		.rd_gnt(rd_gnt),
		.wr_addr(wr_addr),
		.wr_data(wr_data),
		.wr_cbe(wr_cbe),
		.wr_complete(wr_complete),
		.rd_addr(rd_addr),
		.rd_cmd(rd_cmd),
		.m_addr_n(m_addr_n),
		.rdata_ready(rdata_ready),
		.adio_in(adio_in),
		.m_cbe(m_cbe),
		.request(request),
		.request_hold(request_hold),
		.m_wrdn(m_wrdn),
		.complete(complete),
		.m_ready(m_ready)
	);

endmodule

`default_nettype wire

// ==== rtl/pci_read_engine.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "pci_bridge_defines.svh"

module pci_read_engine (
	input wire clk,
	input wire rst,
	input wire pci_bridge_pkg::txn_id_t rcmd_id,
	input wire pci_bridge_pkg::beat_len_t rcmd_len,
	input wire pci_bridge_pkg::dword_t rcmd_addr,
	input wire rcmd_valid,
	output logic rcmd_ready,
	output pci_bridge_pkg::txn_id_t rresp_id,
	output pci_bridge_pkg::beat_len_t rresp_len,
	output logic rresp_err,
	output logic rresp_valid,
	input wire rresp_ready,
	output pci_bridge_pkg::dword_t rdata_din,
	output logic rdata_valid,
	input wire rdata_ready,
	input wire pci_bridge_pkg::dword_t adio_out,
	input wire [`PCI_CLS_W-1:0] cacheline_size,
	output logic bus_req,
	input wire bus_gnt,
	output pci_bridge_pkg::dword_t rd_addr,
	output pci_bridge_pkg::bus_cmd_t rd_cmd,
	input wire m_data_vld,
	input wire m_data,
	input wire m_addr_n,
	input wire stopq_n,
	input wire time_out
);

	pci_bridge_pkg::rd_state_t state;
	pci_bridge_pkg::txn_id_t id_r;
	pci_bridge_pkg::beat_len_t len_r;
	pci_bridge_pkg::dword_t cur_addr;
	pci_bridge_pkg::bus_cmd_t sel_cmd;
	logic [`PCI_LEN_W:0] ack_cnt; // Beats delivered on rdata, fill included
	logic [`PCI_LEN_W:0] remain;
	logic [29:0] first_dw;
	logic [29:0] last_dw;
	logic [29:0] line_mask;
	logic disc;
	logic m_data_q;
	logic beat_ack;
	logic fill_take;
	logic last_beat;
	logic data_end;

	assign beat_ack = (state == pci_bridge_pkg::RD_DATA) && m_data_vld;
	assign fill_take = (state == pci_bridge_pkg::RD_FILL) && rdata_ready;
	assign last_beat = ack_cnt == {1'b0, len_r};
	assign data_end = m_data_q && !m_data;

	// Dropping the request on the final beat is what asks the core to complete
	assign bus_req = (state == pci_bridge_pkg::RD_REQ) || (state == pci_bridge_pkg::RD_ADDR) ||
		((state == pci_bridge_pkg::RD_DATA) && !last_beat);

	// The core only raises m_data_vld while m_ready is high, so no beat waits here
	assign rdata_valid = beat_ack || (state == pci_bridge_pkg::RD_FILL);
	assign rdata_din = (state == pci_bridge_pkg::RD_FILL) ? `PCI_FILL_WORD : adio_out;
	assign rd_addr = cur_addr;
	assign rresp_id = id_r;
	assign rresp_len = len_r;

	always_comb begin
		remain = {1'b0, len_r} + 1'b1 - ack_cnt;
		first_dw = cur_addr[`PCI_DWORD_W-1:2];
		last_dw = first_dw + 30'(remain) - 30'd1;
		line_mask = 30'(cacheline_size) - 30'd1;
		if (remain == 1)
			sel_cmd = `PCI_CMD_MEM_READ;
		else if (|((first_dw ^ last_dw) & ~line_mask))
			sel_cmd = `PCI_CMD_MEM_READ_MUL; // Span runs past the current cacheline
		else
			sel_cmd = `PCI_CMD_MEM_READ_LN;
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state <= pci_bridge_pkg::RD_IDLE;
			rcmd_ready <= 1'b0;
			rresp_valid <= 1'b0;
			rresp_err <= 1'b0;
			disc <= 1'b0;
			m_data_q <= 1'b0;
			ack_cnt <= '0;
		end else begin
			m_data_q <= m_data;
			rcmd_ready <= 1'b0;
			if (state == pci_bridge_pkg::RD_IDLE)
				ack_cnt <= '0;
			else if (beat_ack || fill_take)
				ack_cnt <= ack_cnt + 1'b1;
			case (state)
				pci_bridge_pkg::RD_IDLE: begin
					if (rcmd_valid) begin
						rcmd_ready <= 1'b1;
						state <= pci_bridge_pkg::RD_REQ;
					end
				end
				pci_bridge_pkg::RD_REQ: begin
					disc <= 1'b0;
					if (bus_gnt)
						state <= pci_bridge_pkg::RD_ADDR;
				end
				pci_bridge_pkg::RD_ADDR: begin
					if (!m_addr_n)
						state <= pci_bridge_pkg::RD_DATA;
				end
				pci_bridge_pkg::RD_DATA: begin
					if (!stopq_n)
						disc <= 1'b1;
					if (beat_ack && last_beat) begin
						rresp_err <= 1'b0;
						rresp_valid <= 1'b1;
						state <= pci_bridge_pkg::RD_RESP;
					end else if (data_end && (disc || !stopq_n) && !time_out) begin
						state <= pci_bridge_pkg::RD_CONT;
					end else if (data_end || time_out) begin
						state <= pci_bridge_pkg::RD_FILL;
					end
				end
				pci_bridge_pkg::RD_CONT: begin
					if (!bus_gnt)
						state <= pci_bridge_pkg::RD_REQ;
				end
				pci_bridge_pkg::RD_FILL: begin
					if (fill_take && last_beat) begin
						rresp_err <= 1'b1;
						rresp_valid <= 1'b1;
						state <= pci_bridge_pkg::RD_RESP;
					end
				end
				pci_bridge_pkg::RD_RESP: begin
					if (rresp_ready) begin
						rresp_valid <= 1'b0;
						state <= pci_bridge_pkg::RD_IDLE;
					end
				end
				default: state <= pci_bridge_pkg::RD_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == pci_bridge_pkg::RD_IDLE && rcmd_valid) begin
			id_r <= rcmd_id;
			len_r <= rcmd_len;
			cur_addr <= {rcmd_addr[`PCI_DWORD_W-1:2], 2'b00};
		end else if (beat_ack) begin
			cur_addr <= cur_addr + 32'd4;
		end
		if (state == pci_bridge_pkg::RD_REQ)
			rd_cmd <= sel_cmd; // Chosen again for each retry from what is left
	end

endmodule

`default_nettype wire

// ==== rtl/pci_write_engine.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "pci_bridge_defines.svh"

module pci_write_engine (
	input wire clk,
	input wire rst,
	input wire pci_bridge_pkg::txn_id_t wcmd_id,
	input wire pci_bridge_pkg::beat_len_t wcmd_len,
	input wire pci_bridge_pkg::dword_t wcmd_addr,
	input wire wcmd_valid,
	output logic wcmd_ready,
	output pci_bridge_pkg::buf_idx_t wdata_idx,
	input wire pci_bridge_pkg::dword_t wdata_dout,
	input wire pci_bridge_pkg::byte_en_t wdata_strb,
	output pci_bridge_pkg::txn_id_t wresp_id,
	output pci_bridge_pkg::beat_len_t wresp_len,
	output logic wresp_err,
	output logic wresp_valid,
	input wire wresp_ready,
	output logic bus_req,
	input wire bus_gnt,
	output pci_bridge_pkg::dword_t wr_addr,
	output pci_bridge_pkg::dword_t wr_data,
	output pci_bridge_pkg::byte_en_t wr_cbe,
	output logic wr_complete,
	input wire m_data_vld,
	input wire m_src_en,
	input wire m_data,
	input wire m_addr_n,
	input wire stopq_n,
	input wire time_out
);

	pci_bridge_pkg::wr_state_t state;
	pci_bridge_pkg::txn_id_t id_r;
	pci_bridge_pkg::beat_len_t len_r;
	pci_bridge_pkg::dword_t cur_addr; // Address of the next unacknowledged beat
	pci_bridge_pkg::buf_idx_t buf_base;
	logic [`PCI_LEN_W:0] ack_cnt; // Beats accepted by the target
	logic [`PCI_LEN_W:0] src_cnt; // Beats handed to the core
	logic disc;
	logic m_data_q;
	logic moving;
	logic beat_ack;
	logic last_ack;
	logic data_end;

	assign moving = (state == pci_bridge_pkg::WR_ADDR) || (state == pci_bridge_pkg::WR_DATA);
	assign beat_ack = (state == pci_bridge_pkg::WR_DATA) && m_data_vld;
	assign last_ack = ack_cnt == {1'b0, len_r};
	assign data_end = m_data_q && !m_data; // Falling edge of m_data closes the tenure

	assign bus_req = (state == pci_bridge_pkg::WR_REQ) || moving;
	assign wr_addr = cur_addr;
	assign wr_data = wdata_dout;
	assign wr_cbe = ~wdata_strb;
	assign wr_complete = moving && ((src_cnt == {1'b0, len_r}) || !stopq_n);
	assign wdata_idx = buf_base + pci_bridge_pkg::buf_idx_t'(src_cnt);
	assign wresp_id = id_r;
	assign wresp_len = len_r;

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state <= pci_bridge_pkg::WR_IDLE;
			wcmd_ready <= 1'b0;
			wresp_valid <= 1'b0;
			wresp_err <= 1'b0;
			disc <= 1'b0;
			m_data_q <= 1'b0;
		end else begin
			m_data_q <= m_data;
			wcmd_ready <= 1'b0;
			case (state)
				pci_bridge_pkg::WR_IDLE: begin
					if (wcmd_valid) begin
						wcmd_ready <= 1'b1;
						state <= pci_bridge_pkg::WR_REQ;
					end
				end
				pci_bridge_pkg::WR_REQ: begin
					disc <= 1'b0;
					if (bus_gnt)
						state <= pci_bridge_pkg::WR_ADDR;
				end
				pci_bridge_pkg::WR_ADDR: begin
					if (!m_addr_n)
						state <= pci_bridge_pkg::WR_DATA;
				end
				pci_bridge_pkg::WR_DATA: begin
					if (!stopq_n)
						disc <= 1'b1;
					if (beat_ack && last_ack) begin
						wresp_err <= 1'b0;
						wresp_valid <= 1'b1;
						state <= pci_bridge_pkg::WR_RESP;
					end else if (data_end && (disc || !stopq_n) && !time_out) begin
						state <= pci_bridge_pkg::WR_CONT;
					end else if (data_end || time_out) begin
						wresp_err <= 1'b1; // Master abort or latency timeout
						wresp_valid <= 1'b1;
						state <= pci_bridge_pkg::WR_RESP;
					end
				end
				pci_bridge_pkg::WR_CONT: begin
					if (!bus_gnt)
						state <= pci_bridge_pkg::WR_REQ;
				end
				pci_bridge_pkg::WR_RESP: begin
					if (wresp_ready) begin
						wresp_valid <= 1'b0;
						state <= pci_bridge_pkg::WR_IDLE;
					end
				end
				default: state <= pci_bridge_pkg::WR_IDLE;
			endcase
		end
	end

	// Source count is rewound to the acknowledged count before every retry
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			ack_cnt <= '0;
			src_cnt <= '0;
			buf_base <= '0;
		end else begin
			if (state == pci_bridge_pkg::WR_IDLE)
				ack_cnt <= '0;
			else if (beat_ack)
				ack_cnt <= ack_cnt + 1'b1;
			if (state == pci_bridge_pkg::WR_IDLE || state == pci_bridge_pkg::WR_REQ)
				src_cnt <= (state == pci_bridge_pkg::WR_IDLE) ? '0 : ack_cnt;
			else if (moving && m_src_en)
				src_cnt <= src_cnt + 1'b1;
			if (wresp_valid && wresp_ready)
				buf_base <= buf_base + pci_bridge_pkg::buf_idx_t'(ack_cnt);
		end
	end

	always_ff @(posedge clk) begin
		if (state == pci_bridge_pkg::WR_IDLE && wcmd_valid) begin
			id_r <= wcmd_id;
			len_r <= wcmd_len;
			cur_addr <= {wcmd_addr[`PCI_DWORD_W-1:2], 2'b00};
		end else if (beat_ack) begin
			cur_addr <= cur_addr + 32'd4;
		end
	end

endmodule

`default_nettype wire

// ==== tb/pci_core_model.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "pci_bridge_defines.svh"

module pci_core_model (
	input wire clk,
	input wire pci_bridge_pkg::dword_t adio_in,
	output pci_bridge_pkg::dword_t adio_out,
	input wire request,
	input wire pci_bridge_pkg::bus_cmd_t m_cbe,
	input wire m_wrdn,
	input wire complete,
	input wire m_ready,
	output logic m_data_vld,
	output logic m_src_en,
	output logic time_out,
	output logic m_data,
	output logic m_addr_n,
	output logic stopq_n
);

	pci_bridge_pkg::dword_t mem [0:`PCI_BUF_DEPTH-1];
	pci_bridge_pkg::dword_t addr_log[$];
	pci_bridge_pkg::bus_cmd_t cmd_log[$];
	bit dir_log[$]; // One entry per address phase, 1 for a write
	int disc_after;
	int disc_left;
	int abort_after;
	int abort_left;
	bit wait_en;
	int seed;
	int ph; // 0 idle, 2 address, 3 data, 5 stop, 4 turnaround
	int beats;
	logic [9:0] cur;
	logic cap_wr;
	logic pend; // A request that arrived while the bus was busy
	logic vld_en;

	assign m_data_vld = vld_en && (cap_wr || m_ready);
	assign m_src_en = m_data_vld && cap_wr;
	assign time_out = 1'b0;

	initial begin
		seed = 32'ha57585f1;
		disc_after = 0;
		disc_left = 0;
		abort_after = 0;
		abort_left = 0;
		wait_en = 0;
		ph = 0;
		beats = 0;
		cur = '0;
		cap_wr = 1'b0;
		pend = 1'b0;
		vld_en = 1'b0;
		m_data = 1'b0;
		m_addr_n = 1'b1;
		stopq_n = 1'b1;
		adio_out = '0;
		for (int i = 0; i < `PCI_BUF_DEPTH; i++)
			mem[i] = 32'hC3000000 ^ (i << 16) ^ i;
	end

	always @(posedge clk) begin
		if (ph == 0 || ph == 4) begin
			ph <= (request || pend) ? 2 : 0;
			pend <= 1'b0;
		end else begin
			if (request)
				pend <= 1'b1;
			if (ph == 2) begin
				addr_log.push_back(adio_in);
				cmd_log.push_back(m_cbe);
				dir_log.push_back(m_wrdn);
				cur <= adio_in[11:2];
				cap_wr <= m_wrdn;
				beats <= 0;
				ph <= 3;
			end else if (ph == 5) begin
				ph <= 4;
			end else if (ph == 3 && m_data_vld) begin
				if (cap_wr)
					for (int b = 0; b < 4; b++)
						if (!m_cbe[b])
							mem[cur][8*b +: 8] <= adio_in[8*b +: 8]; // Enables are active low
				cur <= cur + 1'b1;
				beats <= beats + 1;
				if (complete) begin
					ph <= 4;
				end else if (disc_left > 0 && beats + 1 == disc_after) begin
					ph <= 5;
					disc_left <= disc_left - 1;
				end else if (abort_left > 0 && beats + 1 == abort_after) begin
					ph <= 4; // Data ends without stop, as a master abort looks
					abort_left <= abort_left - 1;
				end
			end
		end
	end

	always @(negedge clk) begin
		m_addr_n <= ph != 2;
		m_data <= ph == 3 || ph == 5;
		stopq_n <= ph != 5;
		vld_en <= ph == 3 && (!wait_en || ($random(seed) & 3) != 0);
		adio_out <= mem[cur];
	end

endmodule

`default_nettype wire

// ==== tb/pci_master_chk.sv ====
`timescale 1ns/10ps
`default_nettype none

module pci_master_chk (
	input wire clk,
	input wire rst,
	input wire wr_gnt,
	input wire rd_gnt,
	input wire request,
	input wire wresp_valid,
	input wire wresp_ready,
	input wire rresp_valid,
	input wire rresp_ready
);

	one_grant: assert property (@(posedge clk) disable iff (rst) !(wr_gnt && rd_gnt))
		else $error("both engines hold a grant");

	request_granted: assert property (@(posedge clk) disable iff (rst)
		request |-> (wr_gnt || rd_gnt))
		else $error("request raised without a grant");

	wresp_held: assert property (@(posedge clk) disable iff (rst)
		(wresp_valid && !wresp_ready) |=> wresp_valid)
		else $error("wresp_valid dropped before ready");

	rresp_held: assert property (@(posedge clk) disable iff (rst)
		(rresp_valid && !rresp_ready) |=> rresp_valid)
		else $error("rresp_valid dropped before ready");

endmodule

// The grant wires are internal to the top level, next to the response channels
bind pci_master_top pci_master_chk chk_i (
	.clk(clk),
	.rst(rst),
	.wr_gnt(wr_gnt),
	.rd_gnt(rd_gnt),
	.request(request),
	.wresp_valid(wresp_valid),
	.wresp_ready(wresp_ready),
	.rresp_valid(rresp_valid),
	.rresp_ready(rresp_ready)
);

`default_nettype wire

// ==== tb/tb_pci_master.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "pci_bridge_defines.svh"

module tb_pci_master;

	localparam int TIMEOUT_CYCLES = 20000; // About ten times the longest run of all tests

	logic clk;
	logic rst;
	pci_bridge_pkg::dword_t adio_in;
	pci_bridge_pkg::dword_t adio_out;
	logic request;
	logic request_hold;
	pci_bridge_pkg::bus_cmd_t m_cbe;
	logic m_wrdn;
	logic complete;
	logic m_ready;
	logic m_data_vld;
	logic m_src_en;
	logic time_out;
	logic m_data;
	logic m_addr_n;
	logic stopq_n;
	pci_bridge_pkg::txn_id_t wcmd_id;
	pci_bridge_pkg::beat_len_t wcmd_len;
	pci_bridge_pkg::dword_t wcmd_addr;
	logic wcmd_valid;
	logic wcmd_ready;
	pci_bridge_pkg::buf_idx_t wdata_idx;
	pci_bridge_pkg::dword_t wdata_dout;
	pci_bridge_pkg::byte_en_t wdata_strb;
	pci_bridge_pkg::txn_id_t wresp_id;
	pci_bridge_pkg::beat_len_t wresp_len;
	logic wresp_err;
	logic wresp_valid;
	logic wresp_ready;
	pci_bridge_pkg::txn_id_t rcmd_id;
	pci_bridge_pkg::beat_len_t rcmd_len;
	pci_bridge_pkg::dword_t rcmd_addr;
	logic rcmd_valid;
	logic rcmd_ready;
	pci_bridge_pkg::txn_id_t rresp_id;
	pci_bridge_pkg::beat_len_t rresp_len;
	logic rresp_err;
	logic rresp_valid;
	logic rresp_ready;
	pci_bridge_pkg::dword_t rdata_din;
	logic rdata_valid;
	logic rdata_ready;
	logic [`PCI_CLS_W-1:0] cacheline_size;

	pci_bridge_pkg::dword_t wbuf [0:`PCI_BUF_DEPTH-1];
	pci_bridge_pkg::byte_en_t wstrb [0:`PCI_BUF_DEPTH-1];
	pci_bridge_pkg::dword_t rd_q[$];
	pci_bridge_pkg::buf_idx_t wr_base; // Where the next write should start in the buffer
	int seed;
	int cycles;
	int errors;
	bit rnd_ready;

	pci_master_top dut_i (.*);
	pci_core_model core_i (.*);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	always @(negedge clk) begin
		wdata_dout <= wbuf[wdata_idx];
		wdata_strb <= wstrb[wdata_idx];
		if (!rst) begin
			rdata_ready <= rnd_ready ? ($random(seed) & 1) : 1'b1;
			wresp_ready <= rnd_ready ? ($random(seed) & 1) : 1'b1;
			rresp_ready <= rnd_ready ? ($random(seed) & 1) : 1'b1;
		end
	end

	always @(posedge clk) begin
		if (rdata_valid && rdata_ready)
			rd_q.push_back(rdata_din);
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles > TIMEOUT_CYCLES) begin
			$display("Timeout: the DUT stopped responding after %0d cycles", cycles);
			$display("TB FAILED");
			$fatal(1, "simulation limit reached");
		end
	end

	task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			errors++;
			$display("FAIL time %0t %s: got %h, expected %h", $time, name, got, exp);
			$display("TB FAILED");
			$fatal(1, "mismatch on %s", name);
		end
	endtask

	function automatic pci_bridge_pkg::dword_t merge_bytes(input pci_bridge_pkg::dword_t old,
		input pci_bridge_pkg::dword_t nw, input pci_bridge_pkg::byte_en_t strb);
		pci_bridge_pkg::dword_t res;
		res = old;
		for (int b = 0; b < 4; b++)
			if (strb[b])
				res[8*b +: 8] = nw[8*b +: 8];
		return res;
	endfunction

	task automatic clear_logs();
		core_i.addr_log.delete();
		core_i.cmd_log.delete();
		core_i.dir_log.delete();
	endtask

	task automatic run_write(input pci_bridge_pkg::txn_id_t id, input pci_bridge_pkg::beat_len_t len,
		input pci_bridge_pkg::dword_t addr, input int n_ack, input logic exp_err);
		pci_bridge_pkg::dword_t old[$];
		int w;
		int k;
		w = addr[11:2];
		for (int i = 0; i <= len; i++)
			old.push_back(core_i.mem[w + i]);
		@(negedge clk);
		wcmd_id = id;
		wcmd_len = len;
		wcmd_addr = addr;
		wcmd_valid = 1'b1;
		do @(posedge clk); while (!wcmd_ready);
		@(negedge clk);
		wcmd_valid = 1'b0;
		do @(posedge clk); while (!(wresp_valid && wresp_ready));
		check("wresp_id", wresp_id, id);
		check("wresp_len", wresp_len, len);
		check("wresp_err", wresp_err, exp_err);
		for (int i = 0; i <= len; i++) begin
			k = (wr_base + i) % `PCI_BUF_DEPTH;
			if (i < n_ack)
				check("memory word", core_i.mem[w + i], merge_bytes(old[i], wbuf[k], wstrb[k]));
			else
				check("untouched memory word", core_i.mem[w + i], old[i]);
		end
		wr_base = wr_base + pci_bridge_pkg::buf_idx_t'(n_ack);
	endtask

	task automatic run_read(input pci_bridge_pkg::txn_id_t id, input pci_bridge_pkg::beat_len_t len,
		input pci_bridge_pkg::dword_t addr, input int n_mem, input logic exp_err);
		pci_bridge_pkg::dword_t exp[$];
		int w;
		w = addr[11:2];
		for (int i = 0; i <= len; i++)
			exp.push_back(i < n_mem ? core_i.mem[w + i] : `PCI_FILL_WORD);
		rd_q.delete();
		@(negedge clk);
		rcmd_id = id;
		rcmd_len = len;
		rcmd_addr = addr;
		rcmd_valid = 1'b1;
		do @(posedge clk); while (!rcmd_ready);
		@(negedge clk);
		rcmd_valid = 1'b0;
		do @(posedge clk); while (!(rresp_valid && rresp_ready));
		check("rresp_id", rresp_id, id);
		check("rresp_len", rresp_len, len);
		check("rresp_err", rresp_err, exp_err);
		check("rdata beat count", rd_q.size(), len + 1);
		for (int i = 0; i <= len; i++)
			check("rdata_din", rd_q[i], exp[i]);
	endtask

	task automatic test_write_read();
		run_write(4'h1, 8'd7, 32'h100, 8, 1'b0);
		run_read(4'h2, 8'd7, 32'h100, 8, 1'b0);
	endtask

	task automatic test_cmd_select();
		clear_logs();
		run_read(4'h3, 8'd0, 32'h200, 1, 1'b0);
		run_read(4'h4, 8'd3, 32'h240, 4, 1'b0); // Four dwords inside one 8-dword line
		run_read(4'h5, 8'd3, 32'h258, 4, 1'b0); // Dwords 0x96 to 0x99 cross a line
		check("command single beat", core_i.cmd_log[0], `PCI_CMD_MEM_READ);
		check("command inside line", core_i.cmd_log[1], `PCI_CMD_MEM_READ_LN);
		check("command crossing line", core_i.cmd_log[2], `PCI_CMD_MEM_READ_MUL);
	endtask

	task automatic test_disconnect();
		core_i.disc_after = 3;
		core_i.disc_left = 1;
		clear_logs();
		run_write(4'h6, 8'd9, 32'h300, 10, 1'b0);
		check("write address phases", core_i.addr_log.size(), 2);
		check("write resume address", core_i.addr_log[1], 32'h30C);
		check("write command", core_i.cmd_log[0], `PCI_CMD_MEM_WRITE);
		check("write direction", core_i.dir_log[0], 1'b1);
		core_i.disc_left = 1;
		clear_logs();
		run_read(4'h7, 8'd9, 32'h300, 10, 1'b0);
		check("read address phases", core_i.addr_log.size(), 2);
		check("read first address", core_i.addr_log[0], 32'h300);
		check("read resume address", core_i.addr_log[1], 32'h30C);
		check("read direction", core_i.dir_log[0], 1'b0);
		core_i.disc_after = 0;
	endtask

	task automatic test_abort();
		core_i.abort_after = 2;
		core_i.abort_left = 1;
		run_write(4'h8, 8'd5, 32'h380, 2, 1'b1);
		core_i.abort_left = 1;
		run_read(4'h9, 8'd5, 32'h380, 2, 1'b1);
		core_i.abort_after = 0;
	endtask

	task automatic test_concurrent();
		rnd_ready = 1'b1;
		core_i.wait_en = 1'b1;
		clear_logs();
		for (int i = 0; i < 4; i++) begin
			fork
				run_write(4'hA, 8'd3, 32'h400 + i * 16, 4, 1'b0);
				run_read(4'hB, 8'd4, 32'h800 + i * 32, 5, 1'b0);
			join
		end
		check("address phase count", core_i.dir_log.size(), 8);
		for (int k = 1; k < 8; k++)
			check("direction alternates", core_i.dir_log[k], !core_i.dir_log[k - 1]);
		rnd_ready = 1'b0;
		core_i.wait_en = 1'b0;
	endtask

	task automatic test_back_to_back();
		run_write(4'hC, 8'd4, 32'h500, 5, 1'b0);
		run_write(4'hD, 8'd4, 32'h520, 5, 1'b0); // Memory check uses the continued index
	endtask

	initial begin
		seed = 32'ha57585f1;
		cycles = 0;
		errors = 0;
		rnd_ready = 1'b0;
		wr_base = '0;
		rst = 1'b1;
		wcmd_id = '0;
		wcmd_len = '0;
		wcmd_addr = '0;
		wcmd_valid = 1'b0;
		rcmd_id = '0;
		rcmd_len = '0;
		rcmd_addr = '0;
		rcmd_valid = 1'b0;
		wresp_ready = 1'b0;
		rresp_ready = 1'b0;
		rdata_ready = 1'b0;
		wdata_dout = '0;
		wdata_strb = '0;
		cacheline_size = 8'd8;
		for (int i = 0; i < `PCI_BUF_DEPTH; i++) begin
			wbuf[i] = $random(seed);
			wstrb[i] = $random(seed);
		end
		repeat (2) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		check("request after reset", request, 1'b0);
		check("request_hold after reset", request_hold, 1'b0);
		check("wcmd_ready after reset", wcmd_ready, 1'b0);
		check("rcmd_ready after reset", rcmd_ready, 1'b0);
		check("wresp_valid after reset", wresp_valid, 1'b0);
		check("rresp_valid after reset", rresp_valid, 1'b0);
		check("rdata_valid after reset", rdata_valid, 1'b0);
		check("m_ready after reset", m_ready, 1'b1);
		wresp_ready = 1'b1;
		rresp_ready = 1'b1;
		test_write_read();
		test_cmd_select();
		test_disconnect();
		test_abort();
		test_concurrent();
		test_back_to_back();
		repeat (5) @(posedge clk);
		if (errors == 0)
			$display("TB PASSED");
		else
			$display("TB FAILED");
		$finish;
	end

endmodule

`default_nettype wire
